// File: visa_pkg.sv
package visa_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int probe_width = 256;               // Probe bus bits
    localparam int probe_bytes = probe_width / 8;   // 32 selectable bytes
    localparam int num_lanes   = 4;                 // Debug lanes

    typedef logic [7:0]  lane_sel_t;   // Start id, byte index into probe
    typedef logic [7:0]  dbg_byte_t;   // One lane value
    typedef logic [31:0] wb_word_t;    // Wishbone data word
    typedef logic [1:0]  wb_addr_t;    // Word address

    // ----------------------------------------
    // Register map
    // ----------------------------------------
    localparam wb_addr_t addr_sel    = 2'd0;   // Four start ids
    localparam wb_addr_t addr_ctrl   = 2'd1;   // Disables, trigger setup
    localparam wb_addr_t addr_match  = 2'd2;   // Trigger match byte
    localparam wb_addr_t addr_status = 2'd3;   // Sticky hit, W1C

    // Control word layout, LSB last
    typedef struct packed {
        logic [13:0] rsvd_hi;       // Reads zero
        logic [1:0]  trig_lane;     // Lane watched by trigger
        lane_sel_t   secure_base;   // First secured byte id
        logic [4:0]  rsvd_lo;       // Reads zero
        logic        trig_en;
        logic        customer_dis;
        logic        all_dis;
    } ctrl_t;

    // Same 32 bits seen two ways
    // Select view at addr_sel, control view at addr_ctrl
    typedef union packed {
        lane_sel_t [num_lanes-1:0] sel;   // Lane 0 in low byte
        ctrl_t                     ctrl;
    } visa_reg_u;

endpackage

// File: visa_cfg_if.sv
`timescale 1ns/10ps

// Static configuration from register block to lanes and trigger
interface visa_cfg_if;

    visa_pkg::lane_sel_t [visa_pkg::num_lanes-1:0] lane_sel;   // Per-lane start id
    logic                                          all_dis;
    logic                                          customer_dis;
    visa_pkg::lane_sel_t                           secure_base;
    logic                                          trig_en;
    logic [1:0]                                    trig_lane;
    visa_pkg::dbg_byte_t                           match;

    modport cfg_src (
        output lane_sel, all_dis, customer_dis, secure_base,
        output trig_en, trig_lane, match
    );

    modport cfg_dst (
        input lane_sel, all_dis, customer_dis, secure_base,
        input trig_en, trig_lane, match
    );

endinterface

// File: visa_regs.sv
`timescale 1ns/10ps

module visa_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  visa_pkg::wb_addr_t wb_adr,
    input  visa_pkg::wb_word_t wb_dat_w,
    output visa_pkg::wb_word_t wb_dat_r,
    output logic               wb_ack,
    input  logic               hit_set,    // Pulse from trigger
    visa_cfg_if.cfg_src        cfg
);

    visa_pkg::lane_sel_t [visa_pkg::num_lanes-1:0] sel_q;
    visa_pkg::ctrl_t                               ctrl_q;
    visa_pkg::dbg_byte_t                           match_q;
    logic                                          hit_q;    // Sticky status

    visa_pkg::visa_reg_u wr_u;      // Write data, decoded
    visa_pkg::visa_reg_u rd_u;      // Read data before ack gating
    visa_pkg::ctrl_t     ctrl_wr;   // Write data with reserved bits dropped
    logic                req;       // New access, not yet acked
    logic                wr;

    // ----------------------------------------
    // Bus handshake
    // ----------------------------------------
    assign req  = wb_cyc & wb_stb & ~wb_ack;   // One ack per access
    assign wr   = req & wb_we;
    assign wr_u = wb_dat_w;

    always_ff @(posedge clk) begin
        if (rst) wb_ack <= 1'b0;
        else     wb_ack <= req;                // Single-cycle ack, fixed latency
    end

    // Keep only defined control fields
    always_comb begin
        ctrl_wr              = '0;
        ctrl_wr.all_dis      = wr_u.ctrl.all_dis;
        ctrl_wr.customer_dis = wr_u.ctrl.customer_dis;
        ctrl_wr.trig_en      = wr_u.ctrl.trig_en;
        ctrl_wr.secure_base  = wr_u.ctrl.secure_base;
        ctrl_wr.trig_lane    = wr_u.ctrl.trig_lane;
    end

    // ----------------------------------------
    // Register state
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q   <= '0;
            ctrl_q  <= '0;
            match_q <= '0;
        end else if (wr) begin
            case (wb_adr)
                visa_pkg::addr_sel:   sel_q   <= wr_u.sel;
                visa_pkg::addr_ctrl:  ctrl_q  <= ctrl_wr;
                visa_pkg::addr_match: match_q <= wr_u[7:0];
                default: ;                     // Status handled below
            endcase
        end
    end

    // Hit beats a clear in the same cycle, so no event is lost
    always_ff @(posedge clk) begin
        if (rst)
            hit_q <= 1'b0;
        else if (hit_set)
            hit_q <= 1'b1;
        else if (wr && wb_adr == visa_pkg::addr_status && wb_dat_w[0])
            hit_q <= 1'b0;                     // Write one to clear
    end

    // Read mux, address held by master until ack
    always_comb begin
        rd_u = '0;
        case (wb_adr)
            visa_pkg::addr_sel:    rd_u.sel  = sel_q;
            visa_pkg::addr_ctrl:   rd_u.ctrl = ctrl_q;
            visa_pkg::addr_match:  rd_u      = {24'b0, match_q};
            visa_pkg::addr_status: rd_u      = {31'b0, hit_q};
            default:               rd_u      = '0;
        endcase
    end

    assign wb_dat_r = wb_ack ? visa_pkg::wb_word_t'(rd_u) : '0;   // Zero outside ack

    // Config out to lanes and trigger
    assign cfg.lane_sel     = sel_q;
    assign cfg.all_dis      = ctrl_q.all_dis;
    assign cfg.customer_dis = ctrl_q.customer_dis;
    assign cfg.secure_base  = ctrl_q.secure_base;
    assign cfg.trig_en      = ctrl_q.trig_en;
    assign cfg.trig_lane    = ctrl_q.trig_lane;
    assign cfg.match        = match_q;

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_ack_after_req : assert property (@(posedge clk) disable iff (rst)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb));

    a_ack_single : assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack);

endmodule

// File: visa_lane_mux.sv
`timescale 1ns/10ps

module visa_lane_mux (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [1:0]                          lane_idx,   // Tied at top
    input  logic [visa_pkg::probe_width-1:0]    probe,
    visa_cfg_if.cfg_dst                         cfg,
    output visa_pkg::dbg_byte_t                 dbg
);

    visa_pkg::dbg_byte_t [visa_pkg::probe_bytes-1:0] probe_b;   // Probe as bytes
    visa_pkg::lane_sel_t                             my_sel;
    visa_pkg::dbg_byte_t                             pick;
    logic                                            in_range;
    logic                                            secured;
    logic                                            blank;

    // ----------------------------------------
    // Byte select
    // ----------------------------------------
    assign probe_b = probe;
    assign my_sel  = cfg.lane_sel[lane_idx];     // This lane's start id

    assign in_range = my_sel < visa_pkg::lane_sel_t'(visa_pkg::probe_bytes);
    assign pick     = probe_b[my_sel[4:0]];      // Low bits only, range masked below

    // Masking
    // Secured bytes hidden when customer access is off
    assign secured = cfg.customer_dis && (my_sel >= cfg.secure_base);
    assign blank   = cfg.all_dis | ~in_range | secured;

    always_ff @(posedge clk) begin
        if (rst)        dbg <= '0;
        else if (blank) dbg <= '0;
        else            dbg <= pick;             // One cycle latency
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_all_dis_blank : assert property (@(posedge clk) disable iff (rst)
        cfg.all_dis |=> (dbg == '0));

endmodule

// File: visa_trigger.sv
`timescale 1ns/10ps

module visa_trigger (
    input  logic                                       clk,
    input  logic                                       rst,
    input  visa_pkg::dbg_byte_t [visa_pkg::num_lanes-1:0] lanes,   // Registered lane outputs
    visa_cfg_if.cfg_dst                                cfg,
    output logic                                       trig_pulse,
    output logic                                       hit_set      // To sticky status
);

    visa_pkg::dbg_byte_t watched;   // Lane picked by trig_lane
    logic                eq;
    logic                fire_q;

    // ----------------------------------------
    // Compare
    // ----------------------------------------
    assign watched = lanes[cfg.trig_lane];
    assign eq      = cfg.trig_en && (watched == cfg.match);   // Gated by enable

    always_ff @(posedge clk) begin
        if (rst) fire_q <= 1'b0;
        else     fire_q <= eq;         // High one cycle per matching cycle
    end

    // Same flop feeds pin and status
    assign trig_pulse = fire_q;
    assign hit_set    = fire_q;

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Enable is read from the register block, so this ties both together
    a_pulse_needs_en : assert property (@(posedge clk) disable iff (rst)
        trig_pulse |-> $past(cfg.trig_en));

endmodule

// File: visa_top.sv
`timescale 1ns/10ps

module visa_top (
    input  logic                             clk,
    input  logic                             rst,
    // Wishbone classic slave
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  visa_pkg::wb_addr_t               wb_adr,
    input  visa_pkg::wb_word_t               wb_dat_w,
    output visa_pkg::wb_word_t               wb_dat_r,
    output logic                             wb_ack,
    // Probe and debug lanes
    input  logic [visa_pkg::probe_width-1:0] probe,
    output visa_pkg::dbg_byte_t              dbgbus0,
    output visa_pkg::dbg_byte_t              dbgbus1,
    output visa_pkg::dbg_byte_t              dbgbus2,
    output visa_pkg::dbg_byte_t              dbgbus3,
    output logic                             trig_pulse
);

    visa_pkg::dbg_byte_t [visa_pkg::num_lanes-1:0] lane_out;
    logic                                          hit_set;

    visa_cfg_if cfg_if ();     // Shared config bundle

    // ----------------------------------------
    // Register block
    // ----------------------------------------
    visa_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .hit_set  (hit_set),
        .cfg      (cfg_if.cfg_src)
    );

    // One mux per lane, index tied
    for (genvar i = 0; i < visa_pkg::num_lanes; i++) begin : g_lane
        visa_lane_mux u_lane (
            .clk      (clk),
            .rst      (rst),
            .lane_idx (2'(i)),
            .probe    (probe),
            .cfg      (cfg_if.cfg_dst),
            .dbg      (lane_out[i])
        );
    end

    visa_trigger u_trig (
        .clk        (clk),
        .rst        (rst),
        .lanes      (lane_out),
        .cfg        (cfg_if.cfg_dst),
        .trig_pulse (trig_pulse),
        .hit_set    (hit_set)
    );

    assign dbgbus0 = lane_out[0];
    assign dbgbus1 = lane_out[1];
    assign dbgbus2 = lane_out[2];
    assign dbgbus3 = lane_out[3];

endmodule

// File: tb_visa.sv
`timescale 1ns/10ps

module tb_visa;

    localparam int                 num_ops   = 700;            // Bus accesses plus idle cycles
    localparam int                 ack_limit = 8;              // Cycles before giving up on ack
    localparam visa_pkg::wb_word_t ctrl_mask = 32'h0003_ff07;  // Defined control bits

    logic                             clk;
    logic                             rst;
    logic                             wb_cyc;
    logic                             wb_stb;
    logic                             wb_we;
    visa_pkg::wb_addr_t               wb_adr;
    visa_pkg::wb_word_t               wb_dat_w;
    visa_pkg::wb_word_t               wb_dat_r;
    logic                             wb_ack;
    logic [visa_pkg::probe_width-1:0] probe;
    visa_pkg::dbg_byte_t              dbgbus0;
    visa_pkg::dbg_byte_t              dbgbus1;
    visa_pkg::dbg_byte_t              dbgbus2;
    visa_pkg::dbg_byte_t              dbgbus3;
    logic                             trig_pulse;

    // ----------------------------------------
    // Model state
    // ----------------------------------------
    visa_pkg::lane_sel_t [visa_pkg::num_lanes-1:0] shadow_sel   = '0;
    visa_pkg::ctrl_t                               shadow_ctrl  = '0;
    visa_pkg::dbg_byte_t                           shadow_match = '0;
    logic                                          model_hit    = 1'b0;   // Sticky status
    logic [visa_pkg::probe_width-1:0]              prev_probe   = '0;     // Seen one cycle back
    visa_pkg::lane_sel_t [visa_pkg::num_lanes-1:0] prev_sel     = '0;
    visa_pkg::ctrl_t                               prev_ctrl    = '0;
    visa_pkg::dbg_byte_t                           prev_match   = '0;
    logic                                          prev_rst     = 1'b1;
    visa_pkg::dbg_byte_t [visa_pkg::num_lanes-1:0] exp_lanes    = '0;
    logic                                          exp_pulse    = 1'b0;
    logic                                          force_hit    = 1'b0;   // Plant match bytes
    int                                            pulse_count  = 0;

    visa_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .probe      (probe),
        .dbgbus0    (dbgbus0),
        .dbgbus1    (dbgbus1),
        .dbgbus2    (dbgbus2),
        .dbgbus3    (dbgbus3),
        .trig_pulse (trig_pulse)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                 // 10 ns period
    end

    initial begin
        #((num_ops * 20 + 16) * 10);
        stop_run("watchdog expired before the test sequence finished");
    end

    // ----------------------------------------
    // Reporting and compares
    // ----------------------------------------
    task automatic stop_run(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_byte(input visa_pkg::dbg_byte_t got, input visa_pkg::dbg_byte_t exp,
                              input string what);
        if (got !== exp)
            stop_run($sformatf("MISMATCH at %0t: %s is %02h, expected %02h",
                               $time, what, got, exp));
    endtask

    task automatic check_word(input visa_pkg::wb_word_t got, input visa_pkg::wb_word_t exp,
                              input string what);
        if (got !== exp)
            stop_run($sformatf("MISMATCH at %0t: %s is %08h, expected %08h",
                               $time, what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    // Lane value from the masking rules
    function automatic visa_pkg::dbg_byte_t expect_lane(input logic [255:0] p,
                                                        input visa_pkg::lane_sel_t id,
                                                        input visa_pkg::ctrl_t c);
        if (c.all_dis)
            return '0;
        if (id >= visa_pkg::probe_bytes)
            return '0;                         // Past the end of the probe
        if (c.customer_dis && id >= c.secure_base)
            return '0;
        return p[int'(id) * 8 +: 8];
    endfunction

    function automatic visa_pkg::wb_word_t model_read(input visa_pkg::wb_addr_t adr);
        case (adr)
            visa_pkg::addr_sel:   return shadow_sel;
            visa_pkg::addr_ctrl:  return shadow_ctrl;
            visa_pkg::addr_match: return {24'b0, shadow_match};
            default:              return {31'b0, model_hit};
        endcase
    endfunction

    // Random probe with the watched byte sometimes planted
    function automatic logic [255:0] new_probe();
        logic [255:0]        p;
        visa_pkg::lane_sel_t id;
        for (int k = 0; k < 8; k++)
            p[k * 32 +: 32] = $urandom;
        id = shadow_sel[shadow_ctrl.trig_lane];
        if (force_hit && ($urandom % 4 == 0) && id < visa_pkg::probe_bytes)
            p[int'(id) * 8 +: 8] = shadow_match;
        return p;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
        probe = new_probe();                   // Fresh probe every cycle
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    // ----------------------------------------
    // Wishbone master
    // ----------------------------------------
    task automatic bus_access(input visa_pkg::wb_addr_t adr, input logic we,
                              input visa_pkg::wb_word_t wdata,
                              output visa_pkg::wb_word_t rdata);
        int waited;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        next_cycle();                          // Ack due after this edge
        waited = 1;
        while (!wb_ack && waited < ack_limit) begin
            next_cycle();
            waited++;
        end
        if (!wb_ack)
            stop_run($sformatf("timeout waiting for acknowledge at address %0d", adr));
        check_bit(logic'(waited == 1), 1'b1, "ack one cycle after request");
        rdata = wb_dat_r;
        next_cycle();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        check_bit(wb_ack, 1'b0, "ack one cycle later");   // Single-cycle ack
        check_word(wb_dat_r, '0, "read data outside ack");
    endtask

    task automatic bus_write(input visa_pkg::wb_addr_t adr, input visa_pkg::wb_word_t data);
        visa_pkg::wb_word_t unused;
        bus_access(adr, 1'b1, data, unused);
    endtask

    task automatic bus_read(input visa_pkg::wb_addr_t adr);
        visa_pkg::wb_word_t rd;
        bus_access(adr, 1'b0, '0, rd);
        check_word(rd, model_read(adr), $sformatf("read of address %0d", adr));
    endtask

    task automatic write_random_sel(input int base, input int span);
        visa_pkg::visa_reg_u w;
        for (int n = 0; n < visa_pkg::num_lanes; n++)
            w.sel[n] = visa_pkg::lane_sel_t'(base + $urandom % span);
        bus_write(visa_pkg::addr_sel, w);
    endtask

    // ----------------------------------------
    // Cycle model sampled mid-cycle
    // ----------------------------------------
    always @(negedge clk) begin
        visa_pkg::dbg_byte_t [visa_pkg::num_lanes-1:0] new_lanes;
        logic                                          new_pulse;
        if (rst) begin
            exp_lanes    = '0;
            exp_pulse    = 1'b0;
            model_hit    = 1'b0;
            shadow_sel   = '0;
            shadow_ctrl  = '0;
            shadow_match = '0;
            prev_rst     = 1'b1;
        end else begin
            new_lanes = '0;
            new_pulse = 1'b0;
            if (!prev_rst) begin
                new_pulse = prev_ctrl.trig_en && (exp_lanes[prev_ctrl.trig_lane] == prev_match);
                for (int n = 0; n < visa_pkg::num_lanes; n++)
                    new_lanes[n] = expect_lane(prev_probe, prev_sel[n], prev_ctrl);
            end
            if (exp_pulse)
                model_hit = 1'b1;              // Hit wins over clear
            else if (wb_ack && wb_we && wb_adr == visa_pkg::addr_status && wb_dat_w[0])
                model_hit = 1'b0;
            if (wb_ack && wb_we) begin
                case (wb_adr)
                    visa_pkg::addr_sel:   shadow_sel   = wb_dat_w;
                    visa_pkg::addr_ctrl:  shadow_ctrl  = visa_pkg::ctrl_t'(wb_dat_w & ctrl_mask);
                    visa_pkg::addr_match: shadow_match = wb_dat_w[7:0];
                    default: ;
                endcase
            end
            exp_lanes = new_lanes;
            exp_pulse = new_pulse;
            check_byte(dbgbus0, exp_lanes[0], "dbgbus0");
            check_byte(dbgbus1, exp_lanes[1], "dbgbus1");
            check_byte(dbgbus2, exp_lanes[2], "dbgbus2");
            check_byte(dbgbus3, exp_lanes[3], "dbgbus3");
            check_bit(trig_pulse, exp_pulse, "trig_pulse");
            if (trig_pulse)
                pulse_count++;
            prev_rst = 1'b0;
        end
        prev_probe = probe;                    // DUT samples these at the next edge
        prev_sel   = shadow_sel;
        prev_ctrl  = shadow_ctrl;
        prev_match = shadow_match;
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        visa_pkg::visa_reg_u w;
        visa_pkg::wb_addr_t  a;
        void'($urandom(56841));
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        probe    = '0;
        idle(16);
        rst = 1'b0;

        // Outputs straight out of reset
        check_byte(dbgbus0, '0, "dbgbus0 after reset");
        check_byte(dbgbus1, '0, "dbgbus1 after reset");
        check_byte(dbgbus2, '0, "dbgbus2 after reset");
        check_byte(dbgbus3, '0, "dbgbus3 after reset");
        check_bit(wb_ack, 1'b0, "wb_ack after reset");
        check_bit(trig_pulse, 1'b0, "trig_pulse after reset");
        for (int r = 0; r < 4; r++)
            bus_read(visa_pkg::wb_addr_t'(r));

        // Register readback with reserved control bits dropped
        for (int r = 0; r < 20; r++) begin
            a = visa_pkg::wb_addr_t'($urandom % 3);
            bus_write(a, $urandom);
            bus_read(a);
        end
        bus_read(visa_pkg::addr_status);

        // Lane selection in range then out of range
        bus_write(visa_pkg::addr_ctrl, '0);
        for (int r = 0; r < 4; r++) begin
            write_random_sel(0, visa_pkg::probe_bytes);
            idle(25);
        end
        write_random_sel(visa_pkg::probe_bytes, 256 - visa_pkg::probe_bytes);
        idle(10);
        write_random_sel(0, 256);              // Mix of both
        idle(10);

        // Disables
        write_random_sel(0, visa_pkg::probe_bytes);
        w = '0;
        w.ctrl.all_dis = 1'b1;
        bus_write(visa_pkg::addr_ctrl, w);
        idle(15);
        for (int r = 0; r < 4; r++) begin
            w = '0;
            w.ctrl.customer_dis = 1'b1;
            w.ctrl.secure_base  = visa_pkg::lane_sel_t'($urandom % 40);
            bus_write(visa_pkg::addr_ctrl, w);
            write_random_sel(0, visa_pkg::probe_bytes);
            idle(15);
        end

        // Trigger with planted hits
        pulse_count = 0;                       // Count only pulses from here on
        force_hit   = 1'b1;
        for (int r = 0; r < 4; r++) begin
            write_random_sel(0, visa_pkg::probe_bytes);
            bus_write(visa_pkg::addr_match, $urandom % 256);
            w = '0;
            w.ctrl.trig_en   = 1'b1;
            w.ctrl.trig_lane = 2'($urandom % 4);
            bus_write(visa_pkg::addr_ctrl, w);
            idle(30);
            bus_read(visa_pkg::addr_status);
            w.ctrl.trig_en = 1'b0;
            bus_write(visa_pkg::addr_ctrl, w);
            idle(3);
            bus_write(visa_pkg::addr_status, 32'h1);   // W1C
            bus_read(visa_pkg::addr_status);
        end
        idle(30);                              // Enable off with planted bytes still there
        force_hit = 1'b0;

        if (pulse_count == 0)
            stop_run("no trigger pulse seen during the trigger test");
        else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: visa.f
visa_pkg.sv
visa_cfg_if.sv
visa_regs.sv
visa_lane_mux.sv
visa_trigger.sv
visa_top.sv
tb_visa.sv

// File: Bender.yml
package:
  name: visa

sources:
  # Package first, then interface and modules
  - visa_pkg.sv
  - visa_cfg_if.sv
  - visa_regs.sv
  - visa_lane_mux.sv
  - visa_trigger.sv
  - visa_top.sv

  # Simulation only
  - target: test
    files:
      - tb_visa.sv
